// File: logic/rename_macros.svh
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// Ceiling log2, never narrower than one bit so a depth of one still has an index
`define RN_C2I(x) (((x) <= 1) ? 1 : $clog2(x))

// Width of one architectural register value
`define RN_DATA_WIDTH 32

// Number of architectural registers, register zero included
`define RN_NUM_REGS 32

// Number of reorder-buffer tags in flight at most
`define RN_ROB_DEPTH 16

// Index widths derived from the counts above
`define RN_REG_IDX_WIDTH `RN_C2I(`RN_NUM_REGS)
`define RN_ROB_IDX_WIDTH `RN_C2I(`RN_ROB_DEPTH)

`endif

// File: logic/rename_pkg.sv
`include "rename_macros.svh"

package rename_pkg;

    // Architectural register index
    typedef logic [`RN_REG_IDX_WIDTH-1:0] reg_idx_t;

    // Value held by one architectural register
    typedef logic [`RN_DATA_WIDTH-1:0] reg_data_t;

    // Reorder-buffer tag of an in-flight writer
    typedef logic [`RN_ROB_IDX_WIDTH-1:0] rob_tag_t;

    // Allocator occupancy, one bit wider than a tag so that full fits
    typedef logic [`RN_ROB_IDX_WIDTH:0] rob_count_t;

endpackage

// File: logic/rat_entry.sv
`timescale 1ns/1ps

module rat_entry (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_flush,

    // Rename of this register to a new in-flight writer
    input  logic                  i_rename_en,
    input  rename_pkg::rob_tag_t  i_rename_tag,

    // Retirement of a writer to this register
    input  logic                  i_retire_en,
    input  rename_pkg::reg_data_t i_retire_data,
    input  rename_pkg::rob_tag_t  i_retire_tag,

    output rename_pkg::reg_data_t o_data,
    output rename_pkg::rob_tag_t  o_tag,
    output logic                  o_rdy
);

    rename_pkg::reg_data_t data_q;
    rename_pkg::rob_tag_t  tag_q;
    logic                  rdy_q;
    logic                  tag_match;

    // Only the newest writer may mark the register ready again
    assign tag_match = (tag_q == i_retire_tag);

    // Committed data is written on every retire, even when a rename takes the tag
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            data_q <= '0;
        end else if (i_retire_en && !i_flush) begin
            data_q <= i_retire_data;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tag_q <= '0;
        end else if (i_rename_en && !i_flush) begin
            tag_q <= i_rename_tag;
        end
    end

    // Flush dominates, then a rename clears ready, then a matching retire sets it
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rdy_q <= 1'b1;
        end else if (i_flush) begin
            rdy_q <= 1'b1;
        end else if (i_rename_en) begin
            rdy_q <= 1'b0;
        end else if (i_retire_en && tag_match) begin
            rdy_q <= 1'b1;
        end
    end

    assign o_data = data_q;
    assign o_tag  = tag_q;
    assign o_rdy  = rdy_q;

endmodule

// File: logic/rat.sv
`timescale 1ns/1ps

`include "rename_macros.svh"

module rat (
    input  logic                  clk,
    input  logic                  i_rst_n,

    // Marks every register ready, stale tags are forgotten
    input  logic                  i_flush,

    // Tag update for the destination of a renamed instruction
    input  logic                  i_rename_en,
    input  rename_pkg::reg_idx_t  i_rename_rdst,
    input  rename_pkg::rob_tag_t  i_rename_tag,

    // Committed value from the oldest retiring instruction
    input  logic                  i_retire_en,
    input  rename_pkg::reg_idx_t  i_retire_rdst,
    input  rename_pkg::reg_data_t i_retire_data,
    input  rename_pkg::rob_tag_t  i_retire_tag,

    // Two source operand lookups
    input  rename_pkg::reg_idx_t  i_lookup_rsrc [0:1],
    output logic [1:0]            o_lookup_rdy,
    output rename_pkg::reg_data_t o_lookup_data [0:1],
    output rename_pkg::rob_tag_t  o_lookup_tag [0:1]
);

    localparam int NUM_REGS = `RN_NUM_REGS;

    rename_pkg::reg_data_t entry_data [0:NUM_REGS-1];
    rename_pkg::rob_tag_t  entry_tag [0:NUM_REGS-1];
    logic [NUM_REGS-1:0]   entry_rdy;

    logic [NUM_REGS-1:0]   rename_sel;
    logic [NUM_REGS-1:0]   retire_sel;

    // One-hot write selects, gated by their strobes
    assign rename_sel = {NUM_REGS{i_rename_en}} & ({{(NUM_REGS-1){1'b0}}, 1'b1} << i_rename_rdst);
    assign retire_sel = {NUM_REGS{i_retire_en}} & ({{(NUM_REGS-1){1'b0}}, 1'b1} << i_retire_rdst);

    // Register zero has no storage and always reads as a ready zero
    assign entry_data[0] = '0;
    assign entry_tag[0]  = '0;
    assign entry_rdy[0]  = 1'b1;

    genvar reg_i;
    generate
        for (reg_i = 1; reg_i < NUM_REGS; reg_i++) begin : g_entry
            rat_entry entry_i (
                .clk           (clk),
                .i_rst_n       (i_rst_n),
                .i_flush       (i_flush),
                .i_rename_en   (rename_sel[reg_i]),
                .i_rename_tag  (i_rename_tag),
                .i_retire_en   (retire_sel[reg_i]),
                .i_retire_data (i_retire_data),
                .i_retire_tag  (i_retire_tag),
                .o_data        (entry_data[reg_i]),
                .o_tag         (entry_tag[reg_i]),
                .o_rdy         (entry_rdy[reg_i])
            );
        end
    endgenerate

    // The tag is always the stored one, so a consumer that missed the
    // bypass can still match the result on the same tag later
    always_comb begin
        for (int port = 0; port < 2; port++) begin
            rename_pkg::reg_idx_t src;
            logic                 bypass;

            src = i_lookup_rsrc[port];

            // A not-ready source whose newest writer retires this cycle
            // takes the retiring data straight away
            bypass = i_retire_en
                     && !entry_rdy[src]
                     && (entry_tag[src] == i_retire_tag)
                     && (i_retire_rdst == src);

            o_lookup_rdy[port]  = entry_rdy[src] | bypass;
            o_lookup_data[port] = bypass ? i_retire_data : entry_data[src];
            o_lookup_tag[port]  = entry_tag[src];
        end
    end

endmodule

// File: logic/rob_tag_allocator.sv
`timescale 1ns/1ps

`include "rename_macros.svh"

module rob_tag_allocator (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_flush,

    // Raw requests from the front end and the commit stage
    input  logic                 i_rename_en,
    input  logic                 i_retire_en,

    // Qualified strobes and the tags that go with them
    output logic                 o_rename_fire,
    output rename_pkg::rob_tag_t o_rename_tag,
    output logic                 o_retire_fire,
    output rename_pkg::rob_tag_t o_retire_tag,
    output logic                 o_full
);

    localparam int DEPTH = `RN_ROB_DEPTH;

    rename_pkg::rob_tag_t   head_q;
    rename_pkg::rob_tag_t   tail_q;
    rename_pkg::rob_count_t count_q;
    logic                   full;
    logic                   empty;
    logic                   rename_fire;
    logic                   retire_fire;

    // Next pointer with an explicit wrap, so any depth works
    function automatic rename_pkg::rob_tag_t next_tag(input rename_pkg::rob_tag_t tag);
        if (tag == rename_pkg::rob_tag_t'(DEPTH - 1)) begin
            return '0;
        end
        return tag + 1'b1;
    endfunction

    assign full  = (count_q == rename_pkg::rob_count_t'(DEPTH));
    assign empty = (count_q == '0);

    // A flush cycle drops both requests
    assign rename_fire = i_rename_en && !full && !i_flush;
    assign retire_fire = i_retire_en && !empty && !i_flush;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            head_q <= '0;
            tail_q <= '0;
        end else if (i_flush) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            if (rename_fire) begin
                tail_q <= next_tag(tail_q);
            end
            if (retire_fire) begin
                head_q <= next_tag(head_q);
            end
        end
    end

    // Allocate and free in one cycle leave the count unchanged
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count_q <= '0;
        end else if (i_flush) begin
            count_q <= '0;
        end else if (rename_fire && !retire_fire) begin
            count_q <= count_q + 1'b1;
        end else if (retire_fire && !rename_fire) begin
            count_q <= count_q - 1'b1;
        end
    end

    assign o_rename_fire = rename_fire;
    assign o_rename_tag  = tail_q;
    assign o_retire_fire = retire_fire;
    // Retirement is in order, so the oldest live tag is the one retiring
    assign o_retire_tag  = head_q;
    assign o_full        = full;

endmodule

// File: logic/rename_unit.sv
`timescale 1ns/1ps

module rename_unit (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_flush,

    // Rename request, held by the front end while stalled
    input  logic                  i_rename_en,
    input  rename_pkg::reg_idx_t  i_rename_rdst,
    output rename_pkg::rob_tag_t  o_rename_tag,
    output logic                  o_rename_stall,

    // Retire request, always for the oldest allocated tag
    input  logic                  i_retire_en,
    input  rename_pkg::reg_idx_t  i_retire_rdst,
    input  rename_pkg::reg_data_t i_retire_data,

    // Source operand lookups
    input  rename_pkg::reg_idx_t  i_lookup_rsrc [0:1],
    output logic [1:0]            o_lookup_rdy,
    output rename_pkg::reg_data_t o_lookup_data [0:1],
    output rename_pkg::rob_tag_t  o_lookup_tag [0:1]
);

    logic                 rename_fire;
    rename_pkg::rob_tag_t rename_tag;
    logic                 retire_fire;
    rename_pkg::rob_tag_t retire_tag;

    // Hands out tags in order and qualifies both requests
    rob_tag_allocator alloc_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (i_flush),
        .i_rename_en   (i_rename_en),
        .i_retire_en   (i_retire_en),
        .o_rename_fire (rename_fire),
        .o_rename_tag  (rename_tag),
        .o_retire_fire (retire_fire),
        .o_retire_tag  (retire_tag),
        .o_full        (o_rename_stall)
    );

    // The tag is shown even while stalled, it is only taken when the rename fires
    assign o_rename_tag = rename_tag;

    // Alias table sees only accepted renames and retires
    rat rat_i (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_flush       (i_flush),
        .i_rename_en   (rename_fire),
        .i_rename_rdst (i_rename_rdst),
        .i_rename_tag  (rename_tag),
        .i_retire_en   (retire_fire),
        .i_retire_rdst (i_retire_rdst),
        .i_retire_data (i_retire_data),
        .i_retire_tag  (retire_tag),
        .i_lookup_rsrc (i_lookup_rsrc),
        .o_lookup_rdy  (o_lookup_rdy),
        .o_lookup_data (o_lookup_data),
        .o_lookup_tag  (o_lookup_tag)
    );

endmodule

// File: testbench/rename_unit_tb.sv
`timescale 1ns/1ps

`include "rename_macros.svh"

module rename_unit_tb;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 4;
    localparam int NUM_REGS        = `RN_NUM_REGS;
    localparam int ROB_DEPTH       = `RN_ROB_DEPTH;
    localparam int DIRECTED_CYCLES = 200;
    localparam int RANDOM_CYCLES   = 2000;
    localparam int TIMEOUT_NS      =
        (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * CLK_PERIOD + 2000;

    logic                  clk;
    logic                  rst_n;
    logic                  flush;
    logic                  rename_en;
    rename_pkg::reg_idx_t  rename_rdst;
    rename_pkg::rob_tag_t  rename_tag;
    logic                  rename_stall;
    logic                  retire_en;
    rename_pkg::reg_idx_t  retire_rdst;
    rename_pkg::reg_data_t retire_data;
    rename_pkg::reg_idx_t  lookup_rsrc [0:1];
    logic [1:0]            lookup_rdy;
    rename_pkg::reg_data_t lookup_data [0:1];
    rename_pkg::rob_tag_t  lookup_tag [0:1];

    // Reference model of the alias table and the allocator
    rename_pkg::reg_data_t model_data [0:NUM_REGS-1];
    rename_pkg::rob_tag_t  model_tag [0:NUM_REGS-1];
    logic                  model_rdy [0:NUM_REGS-1];
    rename_pkg::rob_tag_t  pend_tag [$];
    rename_pkg::reg_idx_t  pend_rdst [$];
    int                    rename_count;
    logic                  model_full;
    rename_pkg::rob_tag_t  exp_rename_tag;

    int                    value_errors;
    int                    stall_errors;
    int                    tag_errors;
    int                    check_count;
    integer                seed;
    logic [31:0]           rnd;

    rename_unit dut_i (
        .clk            (clk),
        .i_rst_n        (rst_n),
        .i_flush        (flush),
        .i_rename_en    (rename_en),
        .i_rename_rdst  (rename_rdst),
        .o_rename_tag   (rename_tag),
        .o_rename_stall (rename_stall),
        .i_retire_en    (retire_en),
        .i_retire_rdst  (retire_rdst),
        .i_retire_data  (retire_data),
        .i_lookup_rsrc  (lookup_rsrc),
        .o_lookup_rdy   (lookup_rdy),
        .o_lookup_data  (lookup_data),
        .o_lookup_tag   (lookup_tag)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Stall and offered tag depend on registers only, so both are settled at the falling edge
    stall_follows_model: assert property (@(negedge clk) disable iff (!rst_n)
        rename_stall == model_full)
    else begin
        stall_errors++;
        $display("mismatch at %0t: o_rename_stall is %0b, expected %0b",
                 $time, rename_stall, model_full);
    end

    tag_follows_model: assert property (@(negedge clk) disable iff (!rst_n)
        rename_tag == exp_rename_tag)
    else begin
        tag_errors++;
        $display("mismatch at %0t: o_rename_tag is %0d, expected %0d",
                 $time, rename_tag, exp_rename_tag);
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the test sequence did not finish within %0d ns", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    function automatic rename_pkg::reg_data_t rand_data();
        return $random(seed);
    endfunction

    function automatic rename_pkg::reg_idx_t rand_reg();
        logic [31:0] r;
        r = $random(seed);
        return r[`RN_REG_IDX_WIDTH-1:0];
    endfunction

    task automatic reset_model();
        for (int r = 0; r < NUM_REGS; r++) begin
            model_data[r] = '0;
            model_tag[r]  = '0;
            model_rdy[r]  = 1'b1;
        end
        pend_tag.delete();
        pend_rdst.delete();
        rename_count   = 0;
        model_full     = 1'b0;
        exp_rename_tag = '0;
    endtask

    task automatic clear_requests();
        rename_en = 1'b0;
        retire_en = 1'b0;
        flush     = 1'b0;
    endtask

    // Lookups are combinational, so a bypass needs the retire qualified as the allocator does
    task automatic check_lookups();
        rename_pkg::reg_idx_t  src;
        logic                  exp_rdy;
        rename_pkg::reg_data_t exp_data;
        logic                  retire_fire;
        retire_fire = retire_en && !flush && (pend_tag.size() != 0);
        for (int port = 0; port < 2; port++) begin
            src      = lookup_rsrc[port];
            exp_rdy  = model_rdy[src];
            exp_data = model_data[src];
            if (!exp_rdy && retire_fire && retire_rdst == src
                    && model_tag[src] == pend_tag[0]) begin
                exp_rdy  = 1'b1;
                exp_data = retire_data;
            end
            check_count++;
            assert (lookup_rdy[port] == exp_rdy && lookup_data[port] == exp_data
                    && lookup_tag[port] == model_tag[src])
            else begin
                value_errors++;
                $display("mismatch at %0t: port %0d reg %0d got %0b %h %0d expected %0b %h %0d",
                         $time, port, src, lookup_rdy[port], lookup_data[port],
                         lookup_tag[port], exp_rdy, exp_data, model_tag[src]);
            end
        end
    endtask

    // Retire is judged on the old tag before a same-cycle rename overwrites it
    task automatic update_model();
        logic                 rename_fire;
        logic                 retire_fire;
        rename_pkg::rob_tag_t retire_tag;
        rename_fire = rename_en && !flush && !model_full;
        retire_fire = retire_en && !flush && (pend_tag.size() != 0);
        if (flush) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                model_rdy[r] = 1'b1;
            end
            pend_tag.delete();
            pend_rdst.delete();
            rename_count = 0;
        end else begin
            if (retire_fire) begin
                retire_tag = pend_tag.pop_front();
                void'(pend_rdst.pop_front());
                if (retire_rdst != '0) begin
                    model_data[retire_rdst] = retire_data;
                    if (model_tag[retire_rdst] == retire_tag
                            && !(rename_fire && rename_rdst == retire_rdst)) begin
                        model_rdy[retire_rdst] = 1'b1;
                    end
                end
            end
            if (rename_fire) begin
                pend_tag.push_back(exp_rename_tag);
                pend_rdst.push_back(rename_rdst);
                if (rename_rdst != '0) begin
                    model_tag[rename_rdst] = exp_rename_tag;
                    model_rdy[rename_rdst] = 1'b0;
                end
                rename_count++;
            end
        end
        exp_rename_tag = rename_pkg::rob_tag_t'(rename_count % ROB_DEPTH);
        model_full     = (pend_tag.size() == ROB_DEPTH);
    endtask

    // Starts and ends on a falling edge with the inputs already driven
    task automatic run_cycle();
        #(CLK_PERIOD / 4);
        check_lookups();
        @(posedge clk);
        update_model();
        @(negedge clk);
        clear_requests();
    endtask

    task automatic retire_oldest();
        retire_en = 1'b1;
        if (pend_rdst.size() != 0) begin
            retire_rdst = pend_rdst[0];
        end else begin
            retire_rdst = rand_reg();
        end
        retire_data    = rand_data();
        lookup_rsrc[0] = retire_rdst;
        run_cycle();
    endtask

    task automatic drain_pending();
        while (pend_tag.size() != 0) begin
            retire_oldest();
        end
    endtask

    initial begin
        seed         = 25;
        value_errors = 0;
        stall_errors = 0;
        tag_errors   = 0;
        check_count  = 0;
        rst_n        = 1'b0;
        clear_requests();
        rename_rdst    = '0;
        retire_rdst    = '0;
        retire_data    = '0;
        lookup_rsrc[0] = '0;
        lookup_rsrc[1] = '0;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Every register reads as a ready zero out of reset
        for (int r = 0; r < NUM_REGS; r += 2) begin
            lookup_rsrc[0] = rename_pkg::reg_idx_t'(r);
            lookup_rsrc[1] = rename_pkg::reg_idx_t'(r + 1);
            run_cycle();
        end
        // Register zero ignores a rename and a retire aimed at it
        lookup_rsrc[1] = '0;
        rename_en      = 1'b1;
        rename_rdst    = '0;
        run_cycle();
        retire_oldest();
        run_cycle();

        // Consecutive renames with each register looked up on the cycle after its rename
        for (int r = 5; r < 10; r++) begin
            rename_en      = 1'b1;
            rename_rdst    = rename_pkg::reg_idx_t'(r);
            lookup_rsrc[0] = rename_pkg::reg_idx_t'(r - 1);
            lookup_rsrc[1] = rename_pkg::reg_idx_t'(r);
            run_cycle();
        end
        drain_pending();

        // The older writer retires without readying r7 and the newest one bypasses
        rename_en      = 1'b1;
        rename_rdst    = 5'd7;
        lookup_rsrc[1] = 5'd7;
        run_cycle();
        rename_en   = 1'b1;
        rename_rdst = 5'd7;
        run_cycle();
        retire_oldest();
        retire_oldest();
        run_cycle();
        // A same-cycle rename of the retiring register keeps it waiting
        rename_en   = 1'b1;
        rename_rdst = 5'd7;
        run_cycle();
        rename_en   = 1'b1;
        rename_rdst = 5'd7;
        retire_oldest();
        run_cycle();
        drain_pending();

        // Fill every tag, then stalled renames must leave r30 alone
        for (int r = 1; r <= ROB_DEPTH; r++) begin
            rename_en      = 1'b1;
            rename_rdst    = rename_pkg::reg_idx_t'(r);
            lookup_rsrc[1] = rename_pkg::reg_idx_t'(r - 1);
            run_cycle();
        end
        repeat (2) begin
            rename_en      = 1'b1;
            rename_rdst    = 5'd30;
            lookup_rsrc[1] = 5'd30;
            run_cycle();
        end
        retire_oldest();
        repeat (4) begin
            rename_en   = 1'b1;
            rename_rdst = rand_reg();
            retire_oldest();
        end
        rename_en   = 1'b1;
        rename_rdst = 5'd12;
        run_cycle();
        drain_pending();

        // A flush with pending renames drops the rename and retire of its own cycle
        rename_en   = 1'b1;
        rename_rdst = 5'd3;
        run_cycle();
        retire_oldest();
        rename_en   = 1'b1;
        rename_rdst = 5'd3;
        run_cycle();
        rename_en   = 1'b1;
        rename_rdst = 5'd4;
        run_cycle();
        flush       = 1'b1;
        rename_en   = 1'b1;
        rename_rdst = 5'd9;
        retire_en   = 1'b1;
        retire_rdst = 5'd3;
        retire_data = rand_data();
        run_cycle();
        for (int r = 0; r < NUM_REGS; r += 2) begin
            lookup_rsrc[0] = rename_pkg::reg_idx_t'(r);
            lookup_rsrc[1] = rename_pkg::reg_idx_t'(r + 1);
            run_cycle();
        end
        rename_en      = 1'b1;
        rename_rdst    = 5'd3;
        lookup_rsrc[0] = 5'd3;
        run_cycle();
        run_cycle();
        drain_pending();

        // Random traffic with lookups biased toward the registers in motion
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            rnd         = $random(seed);
            rename_en   = rnd[0] | rnd[1];
            rename_rdst = rand_reg();
            retire_en   = rnd[2] | rnd[3];
            flush       = (rnd[9:4] == 6'd0);
            if (pend_rdst.size() != 0) begin
                retire_rdst = pend_rdst[0];
            end else begin
                retire_rdst = rand_reg();
            end
            retire_data    = rand_data();
            lookup_rsrc[0] = rnd[10] ? retire_rdst : rand_reg();
            lookup_rsrc[1] = rnd[11] ? rename_rdst : rand_reg();
            run_cycle();
        end

        #(CLK_PERIOD / 4);
        $display("Checks %0d, value mismatches %0d, stall mismatches %0d, tag mismatches %0d",
                 check_count, value_errors, stall_errors, tag_errors);
        if (value_errors + stall_errors + tag_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: rename_unit.f
+incdir+logic
logic/rename_pkg.sv
logic/rat_entry.sv
logic/rat.sv
logic/rob_tag_allocator.sv
logic/rename_unit.sv
testbench/rename_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the rename unit testbench with Verilator and runs it.
# The exit status is zero only when the pass message shows up in the output.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f rename_unit.f \
    --top-module rename_unit_tb \
    -Mdir obj_dir \
    -o rename_unit_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/rename_unit_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST RESULT: PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
